// ==== isa_pkg.sv ====
// LEGv8 subset word and field types, opcode values and instruction field positions
package isa_pkg;

  typedef logic [31:0] word_t;    // Data, address and instruction word
  typedef logic [4:0]  reg_idx_t;
  typedef logic [10:0] opcode_t;  // Bits 31:21

  // R-type
  localparam opcode_t OP_ADD  = 11'b10001011000;
  localparam opcode_t OP_SUB  = 11'b11001011000;
  localparam opcode_t OP_AND  = 11'b10001010000;
  localparam opcode_t OP_ORR  = 11'b10101010000;

  // D-type
  localparam opcode_t OP_LDUR = 11'b11111000010;
  localparam opcode_t OP_STUR = 11'b11111000000;

  localparam int    NUM_REGS = 32;
  localparam word_t PC_STEP  = 32'd4;

  // Field positions
  localparam int RD_LSB   = 0;   // Rd, also Rt for loads and stores
  localparam int RN_LSB   = 5;
  localparam int RM_LSB   = 16;
  localparam int DT_LSB   = 12;  // D-type address offset
  localparam int DT_WIDTH = 9;

  // Top of the opcode field
  localparam int OP_MSB   = 31;

endpackage

// ==== pipe_pkg.sv ====
// Control bundle, pipeline register structs, ALU operation and forwarding source enums
package pipe_pkg;
  import isa_pkg::*;

  typedef enum logic [1:0] {
    ALU_AND = 2'b00,
    ALU_ORR = 2'b01,
    ALU_ADD = 2'b10,
    ALU_SUB = 2'b11
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,  // Register file value
    FWD_WB   = 2'b01,
    FWD_MEM  = 2'b10
  } fwd_sel_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src;     // Second operand from imm
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    logic    mem_to_reg;
  } ctrl_t;

  typedef struct packed {
    logic     valid;
    ctrl_t    ctrl;
    word_t    rdata1;
    word_t    rdata2;
    word_t    imm;
    reg_idx_t rn;
    reg_idx_t rm_sel;
    reg_idx_t rd;
  } id_ex_t;

  typedef struct packed {
    logic     valid;
    ctrl_t    ctrl;
    word_t    alu_result;
    word_t    store_data;
    reg_idx_t rd;
  } ex_mem_t;

  typedef struct packed {
    logic     valid;
    logic     reg_write;
    logic     mem_to_reg;
    word_t    alu_result;
    word_t    load_data;
    reg_idx_t rd;
  } mem_wb_t;

endpackage

// ==== decode_unit.sv ====
// Main control decode, second read register select and D-type offset sign extension
module decode_unit (
  input  isa_pkg::word_t    instr,
  output pipe_pkg::ctrl_t   ctrl,
  output isa_pkg::reg_idx_t rm_sel,
  output isa_pkg::word_t    imm
);
  import isa_pkg::*;
  import pipe_pkg::*;

  opcode_t opcode;

  assign opcode = instr[OP_MSB -: $bits(opcode_t)];

  always_comb begin
    ctrl = '0;  // Unknown opcodes become a bubble
    case (opcode)
      OP_ADD: begin
        ctrl.alu_op    = ALU_ADD;
        ctrl.reg_write = 1'b1;
      end
      OP_SUB: begin
        ctrl.alu_op    = ALU_SUB;
        ctrl.reg_write = 1'b1;
      end
      OP_AND: begin
        ctrl.alu_op    = ALU_AND;
        ctrl.reg_write = 1'b1;
      end
      OP_ORR: begin
        ctrl.alu_op    = ALU_ORR;
        ctrl.reg_write = 1'b1;
      end
      OP_LDUR: begin
        ctrl.alu_op     = ALU_ADD;  // Base plus offset
        ctrl.alu_src    = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
      end
      OP_STUR: begin
        ctrl.alu_op    = ALU_ADD;
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      default: ;
    endcase
  end

  // Stores read Rt as the data register
  assign rm_sel = (opcode == OP_STUR) ? instr[RD_LSB +: $bits(reg_idx_t)]
                                      : instr[RM_LSB +: $bits(reg_idx_t)];

  assign imm = {{($bits(word_t) - DT_WIDTH){instr[DT_LSB + DT_WIDTH - 1]}},
                instr[DT_LSB +: DT_WIDTH]};

endmodule

// ==== reg_file.sv ====
// Register file with index-valued reset contents and write-first read ports
module reg_file (
  input  logic              CLOCK,
  input  logic              arst_n,
  input  isa_pkg::reg_idx_t rd_idx_a,
  input  isa_pkg::reg_idx_t rd_idx_b,
  input  logic              wr_en,
  input  isa_pkg::reg_idx_t wr_idx,
  input  isa_pkg::word_t    wr_data,
  output isa_pkg::word_t    rd_data_a,
  output isa_pkg::word_t    rd_data_b
);
  import isa_pkg::*;

  word_t regs [NUM_REGS];

  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= word_t'(i);  // Each register holds its own index
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Writeback in the decode cycle is seen straight away
  assign rd_data_a = (wr_en && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
  assign rd_data_b = (wr_en && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

endmodule

// ==== hazard_unit.sv ====
// Load-use stall detection and execute operand forwarding select
module hazard_unit (
  input  isa_pkg::reg_idx_t  id_rn,
  input  isa_pkg::reg_idx_t  id_rm,
  input  pipe_pkg::ctrl_t    ex_ctrl,
  input  isa_pkg::reg_idx_t  ex_rd,
  input  isa_pkg::reg_idx_t  ex_rn,
  input  isa_pkg::reg_idx_t  ex_rm,
  input  isa_pkg::reg_idx_t  mem_rd,
  input  logic               mem_reg_write,
  input  isa_pkg::reg_idx_t  wb_rd,
  input  logic               wb_reg_write,
  output logic               stall,
  output pipe_pkg::fwd_sel_e fwd_a,
  output pipe_pkg::fwd_sel_e fwd_b
);
  import isa_pkg::*;
  import pipe_pkg::*;

  // Newest result wins
  function automatic fwd_sel_e pick_source(reg_idx_t src);
    if (mem_reg_write && mem_rd == src) begin
      return FWD_MEM;
    end else if (wb_reg_write && wb_rd == src) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  // Load data is not ready until MEM/WB
  assign stall = ex_ctrl.mem_read && (ex_rd == id_rn || ex_rd == id_rm);

  assign fwd_a = pick_source(ex_rn);
  assign fwd_b = pick_source(ex_rm);

endmodule

// ==== execute_unit.sv ====
// Forwarding operand muxes, ALU operation select and ALU
module execute_unit (
  input  pipe_pkg::id_ex_t   ex,
  input  pipe_pkg::fwd_sel_e fwd_a,
  input  pipe_pkg::fwd_sel_e fwd_b,
  input  isa_pkg::word_t     mem_result,
  input  isa_pkg::word_t     wb_result,
  output isa_pkg::word_t     alu_result,
  output isa_pkg::word_t     store_data
);
  import isa_pkg::*;
  import pipe_pkg::*;

  word_t op_a;
  word_t reg_b;  // Forwarded Rm or Rt
  word_t op_b;

  function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val);
    case (sel)
      FWD_MEM: return mem_result;
      FWD_WB:  return wb_result;
      default: return reg_val;
    endcase
  endfunction

  assign op_a  = fwd_mux(fwd_a, ex.rdata1);
  assign reg_b = fwd_mux(fwd_b, ex.rdata2);
  assign op_b  = ex.ctrl.alu_src ? ex.imm : reg_b;

  always_comb begin
    case (ex.ctrl.alu_op)
      ALU_AND: alu_result = op_a & op_b;
      ALU_ORR: alu_result = op_a | op_b;
      ALU_ADD: alu_result = op_a + op_b;
      ALU_SUB: alu_result = op_a - op_b;
      default: alu_result = '0;
    endcase
  end

  assign store_data = reg_b;

endmodule

// ==== legv8_pipeline.sv ====
// Five-stage LEGv8 core top with PC, pipeline registers, memory ports and writeback select
module legv8_pipeline (
  input  logic           CLOCK,
  input  logic           arst_n,
  output isa_pkg::word_t pc,
  input  isa_pkg::word_t instr,
  output isa_pkg::word_t mem_addr,
  output isa_pkg::word_t mem_wdata,
  output logic           mem_read,
  output logic           mem_write,
  input  isa_pkg::word_t mem_rdata
);
  import isa_pkg::*;
  import pipe_pkg::*;

  word_t    if_id_instr;
  logic     if_id_valid;
  id_ex_t   id_ex;
  id_ex_t   id_ex_d;
  ex_mem_t  ex_mem;
  mem_wb_t  mem_wb;

  ctrl_t    dec_ctrl;
  reg_idx_t dec_rm_sel;
  word_t    dec_imm;
  reg_idx_t id_rn;
  reg_idx_t id_rd;
  word_t    rf_a;
  word_t    rf_b;

  logic     stall;
  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;
  word_t    ex_alu_result;
  word_t    ex_store_data;

  logic     wb_we;
  word_t    wb_data;

  assign id_rn = if_id_instr[RN_LSB +: $bits(reg_idx_t)];
  assign id_rd = if_id_instr[RD_LSB +: $bits(reg_idx_t)];

  // Fetch
  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      pc          <= '0;
      if_id_instr <= '0;
      if_id_valid <= 1'b0;
    end else if (!stall) begin
      pc          <= pc + PC_STEP;
      if_id_instr <= instr;
      if_id_valid <= 1'b1;
    end
  end

  decode_unit decode_unit_inst (
    .instr  (if_id_instr),
    .ctrl   (dec_ctrl),
    .rm_sel (dec_rm_sel),
    .imm    (dec_imm)
  );

  reg_file reg_file_inst (
    .CLOCK     (CLOCK),
    .arst_n    (arst_n),
    .rd_idx_a  (id_rn),
    .rd_idx_b  (dec_rm_sel),
    .wr_en     (wb_we),
    .wr_idx    (mem_wb.rd),
    .wr_data   (wb_data),
    .rd_data_a (rf_a),
    .rd_data_b (rf_b)
  );

  hazard_unit hazard_unit_inst (
    .id_rn         (id_rn),
    .id_rm         (dec_rm_sel),
    .ex_ctrl       (id_ex.ctrl),
    .ex_rd         (id_ex.rd),
    .ex_rn         (id_ex.rn),
    .ex_rm         (id_ex.rm_sel),
    .mem_rd        (ex_mem.rd),
    .mem_reg_write (ex_mem.valid & ex_mem.ctrl.reg_write),
    .wb_rd         (mem_wb.rd),
    .wb_reg_write  (wb_we),
    .stall         (stall),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b)
  );

  always_comb begin
    id_ex_d = '0;  // Bubble while stalled
    if (!stall) begin
      id_ex_d.valid  = if_id_valid;
      id_ex_d.ctrl   = dec_ctrl;
      id_ex_d.rdata1 = rf_a;
      id_ex_d.rdata2 = rf_b;
      id_ex_d.imm    = dec_imm;
      id_ex_d.rn     = id_rn;
      id_ex_d.rm_sel = dec_rm_sel;
      id_ex_d.rd     = id_rd;
    end
  end

  execute_unit execute_unit_inst (
    .ex         (id_ex),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .mem_result (ex_mem.alu_result),
    .wb_result  (wb_data),
    .alu_result (ex_alu_result),
    .store_data (ex_store_data)
  );

  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
    end else begin
      id_ex <= id_ex_d;

      ex_mem.valid      <= id_ex.valid;
      ex_mem.ctrl       <= id_ex.ctrl;
      ex_mem.alu_result <= ex_alu_result;
      ex_mem.store_data <= ex_store_data;
      ex_mem.rd         <= id_ex.rd;

      mem_wb.valid      <= ex_mem.valid;
      mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
      mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
      mem_wb.alu_result <= ex_mem.alu_result;
      mem_wb.load_data  <= mem_rdata;
      mem_wb.rd         <= ex_mem.rd;
    end
  end

  // Data memory port, word indexed
  assign mem_addr  = ex_mem.alu_result;
  assign mem_wdata = ex_mem.store_data;
  assign mem_read  = ex_mem.valid & ex_mem.ctrl.mem_read;
  assign mem_write = ex_mem.valid & ex_mem.ctrl.mem_write;

  assign wb_we   = mem_wb.valid & mem_wb.reg_write;
  assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

// ==== legv8_properties.sv ====
// Bound concurrent assertions on the data memory strobes and the program counter
module legv8_properties (
  input logic           CLOCK,
  input logic           arst_n,
  input isa_pkg::word_t pc,
  input logic           mem_read,
  input logic           mem_write
);
  timeunit 1ns;
  timeprecision 1ps;
  import isa_pkg::*;

  strobes_exclusive: assert property (@(posedge CLOCK) disable iff (!arst_n)
    !(mem_read && mem_write))
    else $error("mem_read and mem_write high in the same cycle");

  strobes_idle_in_reset: assert property (@(posedge CLOCK)
    !arst_n |-> (!mem_read && !mem_write))
    else $error("memory strobe high while reset is asserted");

  // No branches, so pc only holds on a stall
  pc_step: assert property (@(posedge CLOCK) disable iff (!arst_n)
    (pc == $past(pc)) || (pc == $past(pc) + PC_STEP))
    else $error("pc moved by something other than 0 or PC_STEP");

endmodule

bind legv8_pipeline legv8_properties legv8_properties_inst (
  .CLOCK     (CLOCK),
  .arst_n    (arst_n),
  .pc        (pc),
  .mem_read  (mem_read),
  .mem_write (mem_write)
);

// ==== legv8_tb.sv ====
// Testbench with clock, reset, instruction and data memory models, directed tests and result line
module legv8_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import isa_pkg::*;

  localparam time CLK_PERIOD  = 40ns;
  localparam time DRIVE_DELAY = 2ns;
  localparam int  IMEM_AW     = 6;
  localparam int  IMEM_WORDS  = 1 << IMEM_AW;
  localparam int  DMEM_WORDS  = 32;
  localparam int  MAX_CYCLES  = 100;

  logic     CLOCK;
  logic     arst_n;
  word_t    pc;
  word_t    instr;
  word_t    mem_addr;
  word_t    mem_wdata;
  word_t    mem_rdata;
  logic     mem_read;
  logic     mem_write;
  word_t    fetch_idx;
  reg_idx_t dmem_slot;

  word_t    imem [IMEM_WORDS];
  word_t    dmem [DMEM_WORDS];
  word_t    model_rf [NUM_REGS];
  word_t    model_mem [DMEM_WORDS];
  word_t    log_addr [$];
  word_t    log_data [$];
  word_t    exp_addr [$];
  word_t    exp_data [$];
  int       prog_len;
  int       pc_holds;
  int       value_errors;
  int       other_errors;

  legv8_pipeline legv8_pipeline_inst (
    .CLOCK     (CLOCK),
    .arst_n    (arst_n),
    .pc        (pc),
    .instr     (instr),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_rdata (mem_rdata)
  );

  initial begin
    CLOCK = 1'b0;
    forever #(CLK_PERIOD / 2) CLOCK = ~CLOCK;
  end

  // Memories answer in the same cycle
  assign fetch_idx = pc / PC_STEP;
  assign instr     = (fetch_idx < word_t'(IMEM_WORDS)) ? imem[fetch_idx[IMEM_AW-1:0]] : '0;
  assign dmem_slot = reg_idx_t'(mem_addr);  // Word index modulo 32
  assign mem_rdata = mem_read ? dmem[dmem_slot] : '0;  // Load data only on a read strobe

  always @(posedge CLOCK) begin
    if (mem_write) begin
      dmem[dmem_slot] = mem_wdata;
      log_addr.push_back(mem_addr);
      log_data.push_back(mem_wdata);
    end
  end

  task automatic check_word(string name, word_t got, word_t expected);
    if (got !== expected) begin
      value_errors++;
      $display("Fail %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic check_bit(string name, logic got, logic expected);
    if (got !== expected) begin
      value_errors++;
      $display("Fail %s: got %h, expected %h", name, got, expected);
    end
  endtask

  function automatic word_t enc_r(opcode_t op, reg_idx_t rd, reg_idx_t rn, reg_idx_t rm);
    return {op, rm, 6'd0, rn, rd};
  endfunction

  function automatic word_t enc_d(opcode_t op, reg_idx_t rt, reg_idx_t rn,
                                  logic [DT_WIDTH-1:0] off);
    return {op, off, 2'b00, rn, rt};
  endfunction

  function automatic word_t sext_offset(logic [DT_WIDTH-1:0] off);
    return {{(32 - DT_WIDTH){off[DT_WIDTH-1]}}, off};
  endfunction

  // Fresh program, memories and reference model
  task automatic start_program();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i]      = word_t'(i * 5);
      model_mem[i] = word_t'(i * 5);
    end
    for (int i = 0; i < NUM_REGS; i++) begin
      model_rf[i] = word_t'(i);
    end
    log_addr.delete();
    log_data.delete();
    exp_addr.delete();
    exp_data.delete();
    prog_len = 0;
  endtask

  task automatic emit_raw(word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  task automatic emit_alu(opcode_t op, reg_idx_t rd, reg_idx_t rn, reg_idx_t rm);
    word_t a;
    word_t b;
    a = model_rf[rn];
    b = model_rf[rm];
    emit_raw(enc_r(op, rd, rn, rm));
    case (op)
      OP_ADD:  model_rf[rd] = a + b;
      OP_SUB:  model_rf[rd] = a - b;
      OP_AND:  model_rf[rd] = a & b;
      default: model_rf[rd] = a | b;
    endcase
  endtask

  task automatic emit_ldur(reg_idx_t rt, reg_idx_t rn, logic [DT_WIDTH-1:0] off);
    word_t addr;
    addr = model_rf[rn] + sext_offset(off);
    emit_raw(enc_d(OP_LDUR, rt, rn, off));
    model_rf[rt] = model_mem[reg_idx_t'(addr)];
  endtask

  task automatic emit_stur(reg_idx_t rt, reg_idx_t rn, logic [DT_WIDTH-1:0] off);
    word_t addr;
    addr = model_rf[rn] + sext_offset(off);
    emit_raw(enc_d(OP_STUR, rt, rn, off));
    exp_addr.push_back(addr);
    exp_data.push_back(model_rf[rt]);
    model_mem[reg_idx_t'(addr)] = model_rf[rt];
  endtask

  task automatic apply_reset();
    arst_n = 1'b0;
    repeat (3) begin
      @(posedge CLOCK);
      #DRIVE_DELAY;
      check_word("pc in reset", pc, '0);
      check_bit("mem_read in reset", mem_read, 1'b0);
      check_bit("mem_write in reset", mem_write, 1'b0);
    end
    arst_n = 1'b1;
    check_word("pc after reset", pc, '0);
    check_bit("mem_read after reset", mem_read, 1'b0);
    check_bit("mem_write after reset", mem_write, 1'b0);
  endtask

  // Also counts the cycles in which pc did not move
  task automatic wait_stores(int n);
    int    cycles;
    word_t prev_pc;
    cycles   = 0;
    prev_pc  = pc;
    pc_holds = 0;
    while (log_data.size() < n && cycles < MAX_CYCLES) begin
      @(posedge CLOCK);
      #DRIVE_DELAY;
      if (pc == prev_pc) pc_holds++;
      prev_pc = pc;
      cycles++;
    end
    if (log_data.size() < n) begin
      other_errors++;
      $display("Timeout after %0d cycles, only %0d of %0d stores seen",
               cycles, log_data.size(), n);
    end
  endtask

  task automatic run_program(string name, int exp_holds);
    apply_reset();
    wait_stores(exp_data.size());
    for (int i = 0; i < exp_data.size() && i < log_data.size(); i++) begin
      check_word($sformatf("%s store %0d mem_addr", name, i), log_addr[i], exp_addr[i]);
      check_word($sformatf("%s store %0d mem_wdata", name, i), log_data[i], exp_data[i]);
    end
    if (pc_holds != exp_holds) begin
      other_errors++;
      $display("%s: pc held for %0d cycles instead of %0d", name, pc_holds, exp_holds);
    end
  endtask

  task automatic test_reset();
    start_program();
    apply_reset();
    @(posedge CLOCK);
    #DRIVE_DELAY;
    check_word("pc first step", pc, PC_STEP);
  endtask

  task automatic test_alu_forwarding();
    start_program();
    emit_alu(OP_ADD, 5'd1, 5'd2, 5'd3);
    emit_alu(OP_SUB, 5'd4, 5'd1, 5'd2);  // EX/MEM forward
    emit_alu(OP_AND, 5'd5, 5'd4, 5'd1);  // Both paths
    emit_alu(OP_ORR, 5'd6, 5'd5, 5'd4);
    emit_stur(5'd6, 5'd10, 9'd3);        // Forwarded store data
    emit_stur(5'd1, 5'd10, 9'd0);
    emit_stur(5'd4, 5'd10, 9'd1);
    emit_stur(5'd5, 5'd10, 9'd2);
    run_program("alu", 0);
  endtask

  task automatic test_load_use();
    start_program();
    emit_ldur(5'd7, 5'd10, 9'd2);
    emit_alu(OP_ADD, 5'd8, 5'd7, 5'd3);
    emit_stur(5'd8, 5'd0, 9'd20);
    run_program("load-use", 1);
  endtask

  task automatic test_writeback_distance();
    start_program();
    emit_alu(OP_ADD, 5'd9, 5'd1, 5'd2);
    emit_alu(OP_ORR, 5'd20, 5'd21, 5'd22);
    emit_alu(OP_AND, 5'd21, 5'd22, 5'd23);
    emit_alu(OP_ADD, 5'd13, 5'd9, 5'd4);  // Reads X9 through the register file
    emit_stur(5'd13, 5'd0, 9'd1);
    run_program("writeback", 0);
  endtask

  task automatic test_unknown_opcodes();
    start_program();
    emit_alu(OP_ADD, 5'd14, 5'd15, 5'd16);
    emit_raw(32'hDEAD_BEEF);  // Rd field is X15
    emit_stur(5'd15, 5'd0, 9'd6);
    emit_raw(32'h9F00_0011);
    emit_alu(OP_SUB, 5'd17, 5'd14, 5'd1);
    emit_raw(32'hFFFF_FFFF);
    emit_stur(5'd14, 5'd0, 9'd5);
    emit_stur(5'd17, 5'd0, 9'd7);
    run_program("unknown", 0);
  endtask

  initial begin
    arst_n       = 1'b0;
    value_errors = 0;
    other_errors = 0;
    test_reset();
    test_alu_forwarding();
    test_load_use();
    test_writeback_distance();
    test_unknown_opcodes();
    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
isa_pkg.sv
pipe_pkg.sv
decode_unit.sv
reg_file.sv
hazard_unit.sv
execute_unit.sv
legv8_pipeline.sv
legv8_properties.sv
legv8_tb.sv

// ==== Makefile ====
# Verilator build and run of the LEGv8 pipeline testbench

VERILATOR ?= verilator
TOP       ?= legv8_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= RESULT: PASS

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
